// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module mem_sub_tb \
		-f mem_sub.f -o mem_sub_sim
	./obj_dir/mem_sub_sim > sim.log 2>&1 || (cat sim.log; false)
	cat sim.log
	! grep -q "tests failed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/dcache_if.sv
`timescale 1ns/1ps

interface dcache_if;

	// load lookup, answered in the same cycle
	logic ld_req;
	mem_pkg::addr_t ld_addr;
	logic hit;
	mem_pkg::data_t hit_data;

	// refill request and broadcast
	logic miss_req;
	logic fill_vld;
	mem_pkg::addr_t fill_addr;
	mem_pkg::data_t fill_data;

	// store drain, held until st_ack
	logic st_req;
	mem_pkg::addr_t st_addr;
	mem_pkg::data_t st_data;
	logic st_ack;

	// bus transfer running or miss queued
	logic busy;

	modport lsq (
		output ld_req, ld_addr, miss_req, st_req, st_addr, st_data,
		input hit, hit_data, fill_vld, fill_addr, fill_data, st_ack, busy
	);

	modport cache (
		input ld_req, ld_addr, miss_req, st_req, st_addr, st_data,
		output hit, hit_data, fill_vld, fill_addr, fill_data, st_ack, busy
	);

endinterface

// File: common/mem_pkg.sv
package mem_pkg;

	// *********************************************************
	// widths
	// *********************************************************
	localparam int ADDR_W = 16;
	localparam int DATA_W = 64;
	localparam int TAG_W = 6;

	// *********************************************************
	// types
	// *********************************************************

	// word address, no byte offset
	typedef logic [ADDR_W-1:0] addr_t;

	typedef logic [DATA_W-1:0] data_t;

	// destination physical register of a load
	typedef logic [TAG_W-1:0] tag_t;

	// dcache bus controller
	typedef enum logic [1:0] {
		WB_IDLE,
		WB_STORE,
		WB_LOAD
	} wb_state_e;

endpackage

// File: design/dcache.sv
`timescale 1ns/1ps

module dcache #(
	parameter int LINES = 16
) (
	input logic clk,
	input logic rst,
	dcache_if.cache dc,
	// wishbone classic master
	output logic wb_cyc_o,
	output logic wb_stb_o,
	output logic wb_we_o,
	output mem_pkg::addr_t wb_adr_o,
	output mem_pkg::data_t wb_dat_o,
	input mem_pkg::data_t wb_dat_i,
	input logic wb_ack_i
);

	localparam int IDX_W = $clog2(LINES);
	localparam int CTAG_W = mem_pkg::ADDR_W - IDX_W;

	logic [CTAG_W-1:0] tag_r [LINES];
	mem_pkg::data_t data_r [LINES];
	logic [LINES-1:0] valid_r;

	mem_pkg::wb_state_e state_r;
	logic miss_pend_r;
	mem_pkg::addr_t miss_addr_r;
	logic fill_vld_r;
	mem_pkg::addr_t fill_addr_r;
	mem_pkg::data_t fill_data_r;

	logic [IDX_W-1:0] ld_idx;
	logic [IDX_W-1:0] st_idx;
	logic [IDX_W-1:0] miss_idx;
	logic st_line_hit;
	logic st_done;
	logic rd_done;

	assign ld_idx = dc.ld_addr[IDX_W-1:0];
	assign st_idx = dc.st_addr[IDX_W-1:0];
	assign miss_idx = miss_addr_r[IDX_W-1:0];

	// *********************************************************
	// lookup
	// *********************************************************
	assign dc.hit = dc.ld_req && valid_r[ld_idx] &&
		(tag_r[ld_idx] == dc.ld_addr[mem_pkg::ADDR_W-1:IDX_W]);
	assign dc.hit_data = data_r[ld_idx];

	// write-update only on a resident line
	assign st_line_hit = valid_r[st_idx] &&
		(tag_r[st_idx] == dc.st_addr[mem_pkg::ADDR_W-1:IDX_W]);

	// *********************************************************
	// bus side
	// *********************************************************
	assign wb_cyc_o = (state_r != mem_pkg::WB_IDLE);
	assign wb_stb_o = wb_cyc_o;
	assign wb_we_o = (state_r == mem_pkg::WB_STORE);
	assign wb_adr_o = wb_we_o ? dc.st_addr : miss_addr_r;
	assign wb_dat_o = dc.st_data;

	assign st_done = (state_r == mem_pkg::WB_STORE) && wb_ack_i;
	assign rd_done = (state_r == mem_pkg::WB_LOAD) && wb_ack_i;

	assign dc.st_ack = st_done;
	assign dc.busy = miss_pend_r || fill_vld_r || (state_r != mem_pkg::WB_IDLE);
	assign dc.fill_vld = fill_vld_r;
	assign dc.fill_addr = fill_addr_r;
	assign dc.fill_data = fill_data_r;

	// stores win over a pending refill
	always_ff @(posedge clk) begin
		if (rst) begin
			state_r <= mem_pkg::WB_IDLE;
			miss_pend_r <= 1'b0;
			fill_vld_r <= 1'b0;
			valid_r <= '0;
		end else begin
			fill_vld_r <= rd_done;
			if (dc.miss_req)
				miss_pend_r <= 1'b1;
			case (state_r)
				mem_pkg::WB_IDLE: begin
					if (dc.st_req)
						state_r <= mem_pkg::WB_STORE;
					else if (miss_pend_r)
						state_r <= mem_pkg::WB_LOAD;
				end
				mem_pkg::WB_STORE: begin
					if (wb_ack_i)
						state_r <= mem_pkg::WB_IDLE;
				end
				mem_pkg::WB_LOAD: begin
					if (wb_ack_i) begin
						state_r <= mem_pkg::WB_IDLE;
						miss_pend_r <= 1'b0;
						valid_r[miss_idx] <= 1'b1;
					end
				end
				default: state_r <= mem_pkg::WB_IDLE;
			endcase
		end
	end

	// line contents and refill broadcast
	always_ff @(posedge clk) begin
		if (dc.miss_req)
			miss_addr_r <= dc.ld_addr;
		if (rd_done) begin
			tag_r[miss_idx] <= miss_addr_r[mem_pkg::ADDR_W-1:IDX_W];
			data_r[miss_idx] <= wb_dat_i;
			fill_addr_r <= miss_addr_r;
			fill_data_r <= wb_dat_i;
		end
		if (st_done && st_line_hit)
			data_r[st_idx] <= dc.st_data;
	end

endmodule

// File: design/mem_sub_top.sv
`timescale 1ns/1ps

module mem_sub_top #(
	parameter int SQ_DEPTH = 8,
	parameter int LQ_DEPTH = 4,
	parameter int LINES = 16
) (
	input logic clk,
	input logic rst,
	// dispatch
	input logic dp_st_i,
	output logic [$clog2(SQ_DEPTH):0] sq_tail_o,
	output logic sq_full_o,
	// store execute and retire
	input logic st_vld_i,
	input logic [$clog2(SQ_DEPTH)-1:0] st_idx_i,
	input mem_pkg::addr_t st_addr_i,
	input mem_pkg::data_t st_data_i,
	input logic st_retire_i,
	// issue check
	input logic [$clog2(SQ_DEPTH):0] iss_pos_i,
	output logic iss_ok_o,
	// load execute and completion
	input logic ld_vld_i,
	input mem_pkg::addr_t ld_addr_i,
	input logic [$clog2(SQ_DEPTH):0] ld_pos_i,
	input mem_pkg::tag_t ld_tag_i,
	output logic ld_ready_o,
	output logic ld_done_o,
	output mem_pkg::data_t ld_data_o,
	output mem_pkg::tag_t ld_tag_o,
	// wishbone
	output logic wb_cyc_o,
	output logic wb_stb_o,
	output logic wb_we_o,
	output mem_pkg::addr_t wb_adr_o,
	output mem_pkg::data_t wb_dat_o,
	input mem_pkg::data_t wb_dat_i,
	input logic wb_ack_i
);

	dcache_if dc_if ();

	lsq #(
		.SQ_DEPTH(SQ_DEPTH),
		.LQ_DEPTH(LQ_DEPTH)
	) lsq_i (
		.clk(clk),
		.rst(rst),
		.dp_st_i(dp_st_i),
		.sq_tail_o(sq_tail_o),
		.sq_full_o(sq_full_o),
		.st_vld_i(st_vld_i),
		.st_idx_i(st_idx_i),
		.st_addr_i(st_addr_i),
		.st_data_i(st_data_i),
		.st_retire_i(st_retire_i),
		.iss_pos_i(iss_pos_i),
		.iss_ok_o(iss_ok_o),
		.ld_vld_i(ld_vld_i),
		.ld_addr_i(ld_addr_i),
		.ld_pos_i(ld_pos_i),
		.ld_tag_i(ld_tag_i),
		.ld_ready_o(ld_ready_o),
		.ld_done_o(ld_done_o),
		.ld_data_o(ld_data_o),
		.ld_tag_o(ld_tag_o),
		.dc(dc_if.lsq)
	);

	dcache #(
		.LINES(LINES)
	) dcache_i (
		.clk(clk),
		.rst(rst),
		.dc(dc_if.cache),
		.wb_cyc_o(wb_cyc_o),
		.wb_stb_o(wb_stb_o),
		.wb_we_o(wb_we_o),
		.wb_adr_o(wb_adr_o),
		.wb_dat_o(wb_dat_o),
		.wb_dat_i(wb_dat_i),
		.wb_ack_i(wb_ack_i)
	);

endmodule

// File: dv/mem_sub_props.sv
`timescale 1ns/1ps

module mem_sub_props (
	input logic clk,
	input logic rst,
	input logic wb_cyc_o,
	input logic wb_stb_o,
	input logic wb_we_o,
	input mem_pkg::addr_t wb_adr_o,
	input logic wb_ack_i,
	input logic ld_done_o
);

	// strobe only inside a cycle
	stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb_o |-> wb_cyc_o)
		else $error("wishbone stb high without cyc");

	// request held until the slave acks
	req_stable: assert property (@(posedge clk) disable iff (rst)
		wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o) && $stable(wb_we_o))
		else $error("wishbone request changed before ack");

	// sampled mid cycle, registers are reset by then
	no_done_in_rst: assert property (@(negedge clk) rst |-> !ld_done_o)
		else $error("load completion during reset");

endmodule

bind mem_sub_top mem_sub_props mem_sub_props_i (
	.clk(clk),
	.rst(rst),
	.wb_cyc_o(wb_cyc_o),
	.wb_stb_o(wb_stb_o),
	.wb_we_o(wb_we_o),
	.wb_adr_o(wb_adr_o),
	.wb_ack_i(wb_ack_i),
	.ld_done_o(ld_done_o)
);

// File: dv/mem_sub_tb.sv
`timescale 1ns/1ps

module mem_sub_tb;

	localparam int SQ_DEPTH = 8;
	localparam int LQ_DEPTH = 4;
	localparam int LINES = 16;
	localparam int SQ_W = $clog2(SQ_DEPTH);
	localparam int N_OPS = 200;
	// ops in flight, keeps tags unique
	localparam int WINDOW = 24;
	localparam mem_pkg::addr_t BASE = 16'h0100;

	logic clk = 1'b0;
	logic rst;
	logic dp_st_i;
	logic [SQ_W:0] sq_tail_o;
	logic sq_full_o;
	logic st_vld_i;
	logic [SQ_W-1:0] st_idx_i;
	mem_pkg::addr_t st_addr_i;
	mem_pkg::data_t st_data_i;
	logic st_retire_i;
	logic [SQ_W:0] iss_pos_i;
	logic iss_ok_o;
	logic ld_vld_i;
	mem_pkg::addr_t ld_addr_i;
	logic [SQ_W:0] ld_pos_i;
	mem_pkg::tag_t ld_tag_i;
	logic ld_ready_o;
	logic ld_done_o;
	mem_pkg::data_t ld_data_o;
	mem_pkg::tag_t ld_tag_o;
	logic wb_cyc_o;
	logic wb_stb_o;
	logic wb_we_o;
	mem_pkg::addr_t wb_adr_o;
	mem_pkg::data_t wb_dat_o;
	mem_pkg::data_t wb_dat_i = '0;
	logic wb_ack_i = 1'b0;

	integer seed;
	int err_cnt;
	int n_tests;
	int fail_tests;
	int n_disp;
	int n_st;
	int ld_act;
	int err_mark;

	// program in dispatch order, op_data holds the expected value for loads
	bit op_st [N_OPS];
	mem_pkg::addr_t op_addr [N_OPS];
	mem_pkg::data_t op_data [N_OPS];
	logic [SQ_W:0] op_pos [N_OPS];
	bit op_exec [N_OPS];
	bit op_done [N_OPS];
	bit op_drained [N_OPS];

	// cache residency as left by completed misses
	bit line_vld [LINES];
	mem_pkg::addr_t line_addr [LINES];

	mem_pkg::data_t mem [64];
	mem_pkg::data_t ref_mem [64];
	mem_pkg::addr_t wr_addr_q [$];
	mem_pkg::data_t wr_data_q [$];
	int miss_q [$];

	logic ack_pend;
	logic [1:0] ack_wait;

	mem_sub_top #(
		.SQ_DEPTH(SQ_DEPTH),
		.LQ_DEPTH(LQ_DEPTH),
		.LINES(LINES)
	) mem_sub_top_i (
		.clk(clk),
		.rst(rst),
		.dp_st_i(dp_st_i),
		.sq_tail_o(sq_tail_o),
		.sq_full_o(sq_full_o),
		.st_vld_i(st_vld_i),
		.st_idx_i(st_idx_i),
		.st_addr_i(st_addr_i),
		.st_data_i(st_data_i),
		.st_retire_i(st_retire_i),
		.iss_pos_i(iss_pos_i),
		.iss_ok_o(iss_ok_o),
		.ld_vld_i(ld_vld_i),
		.ld_addr_i(ld_addr_i),
		.ld_pos_i(ld_pos_i),
		.ld_tag_i(ld_tag_i),
		.ld_ready_o(ld_ready_o),
		.ld_done_o(ld_done_o),
		.ld_data_o(ld_data_o),
		.ld_tag_o(ld_tag_o),
		.wb_cyc_o(wb_cyc_o),
		.wb_stb_o(wb_stb_o),
		.wb_we_o(wb_we_o),
		.wb_adr_o(wb_adr_o),
		.wb_dat_o(wb_dat_o),
		.wb_dat_i(wb_dat_i),
		.wb_ack_i(wb_ack_i)
	);

	always #2 clk = ~clk;

	function automatic mem_pkg::data_t init_word(input mem_pkg::addr_t a);
		init_word = {a ^ 16'h5a3c, ~a, a * 16'd7, a};
	endfunction

	// *********************************************************
	// compare tasks
	// *********************************************************
	task automatic check_data(input mem_pkg::data_t got, input mem_pkg::data_t exp,
			input string what);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_tag(input mem_pkg::tag_t got, input mem_pkg::tag_t exp,
			input string what);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_addr(input mem_pkg::addr_t got, input mem_pkg::addr_t exp,
			input string what);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_pos(input logic [SQ_W:0] got, input logic [SQ_W:0] exp,
			input string what);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s, got %b expected %b", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	// *********************************************************
	// wishbone slave, ack after 1 to 4 cycles
	// *********************************************************
	always @(posedge clk) begin
		if (rst) begin
			wb_ack_i <= 1'b0;
			ack_pend <= 1'b0;
		end else if (wb_ack_i) begin
			wb_ack_i <= 1'b0;
			ack_pend <= 1'b0;
		end else if (wb_cyc_o && wb_stb_o) begin
			if (!ack_pend) begin
				ack_pend <= 1'b1;
				ack_wait <= 2'($random(seed));
			end else if (ack_wait == 2'd0) begin
				wb_ack_i <= 1'b1;
				if (wb_we_o)
					mem[wb_adr_o[5:0]] <= wb_dat_o;
				else
					wb_dat_i <= mem[wb_adr_o[5:0]];
			end else begin
				ack_wait <= ack_wait - 2'd1;
			end
		end
	end

	// stores leave the queue in program order
	function automatic void mark_drained();
		for (int i = 0; i < n_disp; i++) begin
			if (op_st[i] && op_done[i] && !op_drained[i]) begin
				op_drained[i] = 1'b1;
				return;
			end
		end
	endfunction

	// direct mapped, a refill replaces the line
	function automatic void note_refill(input mem_pkg::addr_t a);
		int set_idx;
		set_idx = int'(a) % LINES;
		line_vld[set_idx] = 1'b1;
		line_addr[set_idx] = a;
	endfunction

	// older store still queued, or line resident
	function automatic bit expect_fast(input int k);
		int set_idx;
		set_idx = int'(op_addr[k]) % LINES;
		if (line_vld[set_idx] && line_addr[set_idx] == op_addr[k])
			return 1'b1;
		for (int j = 0; j < k; j++)
			if (op_st[j] && !op_drained[j] && op_addr[j] == op_addr[k])
				return 1'b1;
		return 1'b0;
	endfunction

	// bus writes and load completions, sampled mid cycle
	always @(negedge clk) begin
		int idx;
		if (!rst) begin
			if (wb_cyc_o && wb_we_o && wb_ack_i) begin
				if (wr_addr_q.size() == 0) begin
					$display("bus write at %0t ns with no retired store pending", $time);
					err_cnt++;
				end else begin
					check_addr(wb_adr_o, wr_addr_q.pop_front(), "bus write address");
					check_data(wb_dat_o, wr_data_q.pop_front(), "bus write data");
				end
				mark_drained();
			end
			if (ld_act >= 0) begin
				check_bit(ld_done_o, expect_fast(ld_act), "load completes at once");
				if (ld_done_o) begin
					check_tag(ld_tag_o, mem_pkg::tag_t'(ld_act), "immediate load tag");
					check_data(ld_data_o, op_data[ld_act], "immediate load data");
					op_done[ld_act] = 1'b1;
				end else begin
					miss_q.push_back(ld_act);
				end
			end else if (ld_done_o) begin
				if (miss_q.size() == 0) begin
					$display("load completed at %0t ns with no missed load waiting", $time);
					err_cnt++;
				end else begin
					idx = miss_q.pop_front();
					check_tag(ld_tag_o, mem_pkg::tag_t'(idx), "missed load tag");
					check_data(ld_data_o, op_data[idx], "missed load data");
					op_done[idx] = 1'b1;
					note_refill(op_addr[idx]);
				end
			end
		end
	end

	// *********************************************************
	// program bookkeeping
	// *********************************************************
	function automatic int next_load();
		for (int i = 0; i < n_disp; i++)
			if (!op_st[i] && !op_exec[i])
				return i;
		return -1;
	endfunction

	function automatic int oldest_open();
		for (int i = 0; i < n_disp; i++)
			if (!op_done[i])
				return i;
		return n_disp;
	endfunction

	// oldest unretired store, if every older load is done
	function automatic int retire_cand();
		for (int i = 0; i < n_disp; i++) begin
			if (!op_st[i] && !op_done[i])
				return -1;
			if (op_st[i] && !op_done[i])
				return op_exec[i] ? i : -1;
		end
		return -1;
	endfunction

	function automatic int pick_store();
		int cand [$];
		for (int i = 0; i < n_disp; i++)
			if (op_st[i] && !op_exec[i])
				cand.push_back(i);
		if (cand.size() == 0)
			return -1;
		return cand[$unsigned($random(seed)) % cand.size()];
	endfunction

	// a few hot words mixed with the whole window
	task automatic make_op(input bit is_st);
		int r;
		r = $random(seed);
		check_pos(sq_tail_o, (SQ_W+1)'(n_st), "store queue tail");
		op_st[n_disp] = is_st;
		op_addr[n_disp] = BASE + (r[0] ? mem_pkg::addr_t'(r[3:2]) : mem_pkg::addr_t'(r[9:4]));
		op_pos[n_disp] = sq_tail_o;
		op_exec[n_disp] = 1'b0;
		op_done[n_disp] = 1'b0;
		op_drained[n_disp] = 1'b0;
		if (is_st) begin
			op_data[n_disp] = {$random(seed), $random(seed)};
			ref_mem[op_addr[n_disp][5:0]] = op_data[n_disp];
			n_st++;
		end else begin
			op_data[n_disp] = ref_mem[op_addr[n_disp][5:0]];
		end
		n_disp++;
	endtask

	// kind: 0 dispatch store, 1 dispatch load, 2 execute store, 3 execute load, 4 retire
	task automatic do_action(input int kind, input int idx);
		int k;
		if (kind <= 1)
			make_op(kind == 0);
		@(posedge clk);
		case (kind)
			0: dp_st_i <= 1'b1;
			2: begin
				st_vld_i <= 1'b1;
				st_idx_i <= op_pos[idx][SQ_W-1:0];
				st_addr_i <= op_addr[idx];
				st_data_i <= op_data[idx];
				op_exec[idx] = 1'b1;
			end
			3: begin
				ld_vld_i <= 1'b1;
				ld_addr_i <= op_addr[idx];
				ld_pos_i <= op_pos[idx];
				ld_tag_i <= mem_pkg::tag_t'(idx);
				op_exec[idx] = 1'b1;
				ld_act = idx;
			end
			4: begin
				st_retire_i <= 1'b1;
				wr_addr_q.push_back(op_addr[idx]);
				wr_data_q.push_back(op_data[idx]);
				op_done[idx] = 1'b1;
			end
			default: ;
		endcase
		@(posedge clk);
		dp_st_i <= 1'b0;
		st_vld_i <= 1'b0;
		st_retire_i <= 1'b0;
		ld_vld_i <= 1'b0;
		ld_act = -1;
		k = next_load();
		iss_pos_i <= (k >= 0) ? op_pos[k] : '0;
		@(negedge clk);
	endtask

	task automatic random_step();
		int pick;
		int k;
		bit acted;
		bit exp_ok;
		k = next_load();
		if (k >= 0 && iss_pos_i == op_pos[k]) begin
			exp_ok = 1'b1;
			for (int j = 0; j < k; j++)
				if (op_st[j] && !op_exec[j])
					exp_ok = 1'b0;
			check_bit(iss_ok_o, exp_ok, "iss_ok for next load");
		end
		pick = $unsigned($random(seed)) % 4;
		acted = 1'b0;
		for (int t = 0; t < 4 && !acted; t++) begin
			case ((pick + t) % 4)
				0: begin
					if (n_disp < N_OPS && n_disp - oldest_open() < WINDOW) begin
						if ($random(seed) & 1) begin
							if (!sq_full_o) begin
								do_action(0, 0);
								acted = 1'b1;
							end
						end else begin
							do_action(1, 0);
							acted = 1'b1;
						end
					end
				end
				1: begin
					k = pick_store();
					if (k >= 0) begin
						do_action(2, k);
						acted = 1'b1;
					end
				end
				2: begin
					k = next_load();
					if (k >= 0 && iss_pos_i == op_pos[k] && iss_ok_o && ld_ready_o) begin
						do_action(3, k);
						acted = 1'b1;
					end
				end
				default: begin
					k = retire_cand();
					if (k >= 0) begin
						do_action(4, k);
						acted = 1'b1;
					end
				end
			endcase
		end
		if (!acted)
			@(negedge clk);
	endtask

	task automatic end_test(input string name);
		if (err_cnt == err_mark) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, err_cnt - err_mark);
			fail_tests++;
		end
		n_tests++;
		err_mark = err_cnt;
	endtask

	// *********************************************************
	// main sequence
	// *********************************************************
	initial begin
		seed = 76244;
		rst = 1'b1;
		dp_st_i = 1'b0;
		st_vld_i = 1'b0;
		st_idx_i = '0;
		st_addr_i = '0;
		st_data_i = '0;
		st_retire_i = 1'b0;
		iss_pos_i = '0;
		ld_vld_i = 1'b0;
		ld_addr_i = '0;
		ld_pos_i = '0;
		ld_tag_i = '0;
		ld_act = -1;
		for (int i = 0; i < 64; i++) begin
			mem[i] = init_word(BASE + mem_pkg::addr_t'(i));
			ref_mem[i] = mem[i];
		end
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);

		check_bit(sq_full_o, 1'b0, "sq_full after reset");
		check_bit(ld_done_o, 1'b0, "ld_done after reset");
		check_bit(wb_cyc_o, 1'b0, "wb_cyc after reset");
		check_bit(iss_ok_o, 1'b1, "iss_ok after reset");
		check_bit(ld_ready_o, 1'b1, "ld_ready after reset");
		end_test("reset");

		// full queue with a load behind it
		for (int i = 0; i < SQ_DEPTH; i++)
			do_action(0, 0);
		do_action(1, 0);
		check_bit(sq_full_o, 1'b1, "sq_full with every entry dispatched");
		for (int i = 0; i < SQ_DEPTH; i++) begin
			check_bit(iss_ok_o, 1'b0, "iss_ok with an older store unexecuted");
			do_action(2, pick_store());
		end
		check_bit(iss_ok_o, 1'b1, "iss_ok once older stores executed");
		end_test("issue order and full");

		while (!(n_disp == N_OPS && oldest_open() == N_OPS && wr_addr_q.size() == 0
				&& miss_q.size() == 0 && !wb_cyc_o))
			random_step();
		end_test("random program");

		$display("%0d tests run, %0d with errors, %0d checks wrong", n_tests, fail_tests,
			err_cnt);
		if (err_cnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial begin
		#(N_OPS * 40 * 4);
		$display("watchdog expired before the program finished");
		$display("tests failed");
		$finish;
	end

endmodule

// File: lsq/load_queue.sv
`timescale 1ns/1ps

module load_queue #(
	parameter int LQ_DEPTH = 4
) (
	input logic clk,
	input logic rst,
	// allocate on a miss
	input logic alloc_i,
	input mem_pkg::addr_t alloc_addr_i,
	input mem_pkg::tag_t alloc_tag_i,
	// refill broadcast
	input logic fill_vld_i,
	input mem_pkg::addr_t fill_addr_i,
	input mem_pkg::data_t fill_data_i,
	output logic full_o,
	// completion at the head
	output logic com_vld_o,
	output mem_pkg::data_t com_data_o,
	output mem_pkg::tag_t com_tag_o
);

	localparam int IDX_W = $clog2(LQ_DEPTH);

	logic [IDX_W:0] head_r;
	logic [IDX_W:0] tail_r;
	logic [LQ_DEPTH-1:0] vld_r;
	logic [LQ_DEPTH-1:0] rdy_r;
	mem_pkg::addr_t addr_r [LQ_DEPTH];
	mem_pkg::data_t data_r [LQ_DEPTH];
	mem_pkg::tag_t tag_r [LQ_DEPTH];

	logic [IDX_W-1:0] head_idx;
	logic [IDX_W-1:0] tail_idx;
	logic [LQ_DEPTH-1:0] fill_hit;

	assign head_idx = head_r[IDX_W-1:0];
	assign tail_idx = tail_r[IDX_W-1:0];

	assign full_o = (head_r[IDX_W] != tail_r[IDX_W]) && (head_idx == tail_idx);

	// head pops in the cycle it is offered
	assign com_vld_o = vld_r[head_idx] && rdy_r[head_idx];
	assign com_data_o = data_r[head_idx];
	assign com_tag_o = tag_r[head_idx];

	// every waiting load on the refilled address
	always_comb begin
		for (int k = 0; k < LQ_DEPTH; k++)
			fill_hit[k] = fill_vld_i && vld_r[k] && (addr_r[k] == fill_addr_i);
	end

	// *********************************************************
	// entry control
	// *********************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= '0;
			vld_r <= '0;
			rdy_r <= '0;
		end else begin
			if (alloc_i) begin
				vld_r[tail_idx] <= 1'b1;
				rdy_r[tail_idx] <= 1'b0;
				tail_r <= tail_r + 1'b1;
			end
			for (int k = 0; k < LQ_DEPTH; k++) begin
				if (fill_hit[k])
					rdy_r[k] <= 1'b1;
			end
			if (com_vld_o) begin
				vld_r[head_idx] <= 1'b0;
				rdy_r[head_idx] <= 1'b0;
				head_r <= head_r + 1'b1;
			end
		end
	end

	// *********************************************************
	// payload
	// *********************************************************
	always_ff @(posedge clk) begin
		if (alloc_i) begin
			addr_r[tail_idx] <= alloc_addr_i;
			tag_r[tail_idx] <= alloc_tag_i;
		end
		for (int k = 0; k < LQ_DEPTH; k++) begin
			if (fill_hit[k])
				data_r[k] <= fill_data_i;
		end
	end

endmodule

// File: lsq/lsq.sv
`timescale 1ns/1ps

module lsq #(
	parameter int SQ_DEPTH = 8,
	parameter int LQ_DEPTH = 4
) (
	input logic clk,
	input logic rst,
	input logic dp_st_i,
	output logic [$clog2(SQ_DEPTH):0] sq_tail_o,
	output logic sq_full_o,
	input logic st_vld_i,
	input logic [$clog2(SQ_DEPTH)-1:0] st_idx_i,
	input mem_pkg::addr_t st_addr_i,
	input mem_pkg::data_t st_data_i,
	input logic st_retire_i,
	input logic [$clog2(SQ_DEPTH):0] iss_pos_i,
	output logic iss_ok_o,
	input logic ld_vld_i,
	input mem_pkg::addr_t ld_addr_i,
	input logic [$clog2(SQ_DEPTH):0] ld_pos_i,
	input mem_pkg::tag_t ld_tag_i,
	output logic ld_ready_o,
	output logic ld_done_o,
	output mem_pkg::data_t ld_data_o,
	output mem_pkg::tag_t ld_tag_o,
	dcache_if.lsq dc
);

	logic fwd_vld;
	mem_pkg::data_t fwd_data;
	logic ld_miss;
	logic lq_full;
	logic com_vld;
	mem_pkg::data_t com_data;
	mem_pkg::tag_t com_tag;

	store_queue #(
		.SQ_DEPTH(SQ_DEPTH)
	) store_queue_i (
		.clk(clk),
		.rst(rst),
		.dp_st_i(dp_st_i),
		.sq_tail_o(sq_tail_o),
		.sq_full_o(sq_full_o),
		.st_vld_i(st_vld_i),
		.st_idx_i(st_idx_i),
		.st_addr_i(st_addr_i),
		.st_data_i(st_data_i),
		.st_retire_i(st_retire_i),
		.iss_pos_i(iss_pos_i),
		.iss_ok_o(iss_ok_o),
		.fwd_addr_i(ld_addr_i),
		.fwd_pos_i(ld_pos_i),
		.fwd_vld_o(fwd_vld),
		.fwd_data_o(fwd_data),
		.drain_req_o(dc.st_req),
		.drain_addr_o(dc.st_addr),
		.drain_data_o(dc.st_data),
		.drain_ack_i(dc.st_ack)
	);

	load_queue #(
		.LQ_DEPTH(LQ_DEPTH)
	) load_queue_i (
		.clk(clk),
		.rst(rst),
		.alloc_i(ld_miss),
		.alloc_addr_i(ld_addr_i),
		.alloc_tag_i(ld_tag_i),
		.fill_vld_i(dc.fill_vld),
		.fill_addr_i(dc.fill_addr),
		.fill_data_i(dc.fill_data),
		.full_o(lq_full),
		.com_vld_o(com_vld),
		.com_data_o(com_data),
		.com_tag_o(com_tag)
	);

	// same address feeds forwarding and the cache lookup
	assign dc.ld_req = ld_vld_i;
	assign dc.ld_addr = ld_addr_i;

	assign ld_miss = ld_vld_i && !fwd_vld && !dc.hit;
	assign dc.miss_req = ld_miss;

	assign ld_ready_o = !lq_full && !dc.busy && !com_vld;

	// queued completion, then forward, then hit
	assign ld_done_o = com_vld || (ld_vld_i && (fwd_vld || dc.hit));
	assign ld_data_o = com_vld ? com_data : (fwd_vld ? fwd_data : dc.hit_data);
	assign ld_tag_o = com_vld ? com_tag : ld_tag_i;

endmodule

// File: lsq/store_queue.sv
`timescale 1ns/1ps

module store_queue #(
	parameter int SQ_DEPTH = 8
) (
	input logic clk,
	input logic rst,
	// dispatch
	input logic dp_st_i,
	output logic [$clog2(SQ_DEPTH):0] sq_tail_o,
	output logic sq_full_o,
	// execute and retire
	input logic st_vld_i,
	input logic [$clog2(SQ_DEPTH)-1:0] st_idx_i,
	input mem_pkg::addr_t st_addr_i,
	input mem_pkg::data_t st_data_i,
	input logic st_retire_i,
	// issue check
	input logic [$clog2(SQ_DEPTH):0] iss_pos_i,
	output logic iss_ok_o,
	// forwarding query
	input mem_pkg::addr_t fwd_addr_i,
	input logic [$clog2(SQ_DEPTH):0] fwd_pos_i,
	output logic fwd_vld_o,
	output mem_pkg::data_t fwd_data_o,
	// drain to the cache
	output logic drain_req_o,
	output mem_pkg::addr_t drain_addr_o,
	output mem_pkg::data_t drain_data_o,
	input logic drain_ack_i
);

	localparam int IDX_W = $clog2(SQ_DEPTH);

	// pointers carry a wrap bit on top
	logic [IDX_W:0] head_r;
	logic [IDX_W:0] ret_head_r;
	logic [IDX_W:0] tail_r;
	logic [SQ_DEPTH-1:0] addr_vld_r;
	logic [SQ_DEPTH-1:0] ret_rdy_r;
	mem_pkg::addr_t addr_r [SQ_DEPTH];
	mem_pkg::data_t data_r [SQ_DEPTH];

	logic [IDX_W-1:0] head_idx;
	logic [IDX_W-1:0] ret_idx;
	logic [IDX_W-1:0] tail_idx;
	logic [IDX_W:0] iss_cnt;
	logic [IDX_W:0] fwd_cnt;

	assign head_idx = head_r[IDX_W-1:0];
	assign ret_idx = ret_head_r[IDX_W-1:0];
	assign tail_idx = tail_r[IDX_W-1:0];

	assign sq_tail_o = tail_r;
	assign sq_full_o = (head_r[IDX_W] != tail_r[IDX_W]) && (head_idx == tail_idx);

	// stores older than the queried position
	assign iss_cnt = iss_pos_i - head_r;
	assign fwd_cnt = fwd_pos_i - head_r;

	// *********************************************************
	// age scan, oldest first so the last match is the youngest
	// *********************************************************
	always_comb begin
		logic [IDX_W-1:0] idx;
		iss_ok_o = 1'b1;
		fwd_vld_o = 1'b0;
		fwd_data_o = '0;
		for (int k = 0; k < SQ_DEPTH; k++) begin
			idx = head_idx + IDX_W'(k);
			if (((IDX_W+1)'(k) < iss_cnt) && !addr_vld_r[idx])
				iss_ok_o = 1'b0;
			if (((IDX_W+1)'(k) < fwd_cnt) && addr_vld_r[idx] && (addr_r[idx] == fwd_addr_i)) begin
				fwd_vld_o = 1'b1;
				fwd_data_o = data_r[idx];
			end
		end
	end

	// head store goes out once retired
	assign drain_req_o = ret_rdy_r[head_idx];
	assign drain_addr_o = addr_r[head_idx];
	assign drain_data_o = data_r[head_idx];

	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			ret_head_r <= '0;
			tail_r <= '0;
			addr_vld_r <= '0;
			ret_rdy_r <= '0;
		end else begin
			if (dp_st_i) begin
				addr_vld_r[tail_idx] <= 1'b0;
				tail_r <= tail_r + 1'b1;
			end
			if (st_vld_i)
				addr_vld_r[st_idx_i] <= 1'b1;
			if (st_retire_i) begin
				ret_rdy_r[ret_idx] <= 1'b1;
				ret_head_r <= ret_head_r + 1'b1;
			end
			if (drain_req_o && drain_ack_i) begin
				addr_vld_r[head_idx] <= 1'b0;
				ret_rdy_r[head_idx] <= 1'b0;
				head_r <= head_r + 1'b1;
			end
		end
	end

	// address and data written at execute
	always_ff @(posedge clk) begin
		if (st_vld_i) begin
			addr_r[st_idx_i] <= st_addr_i;
			data_r[st_idx_i] <= st_data_i;
		end
	end

endmodule

// File: mem_sub.f
common/mem_pkg.sv
common/dcache_if.sv
lsq/store_queue.sv
lsq/load_queue.sv
lsq/lsq.sv
design/dcache.sv
design/mem_sub_top.sv
dv/mem_sub_props.sv
dv/mem_sub_tb.sv
